// File: common/rv_core_consts.svh
// ############################
// rv_core constants
// Widths and fixed values shared by the core and its testbench
// ############################

`ifndef RV_CORE_CONSTS_SVH
`define RV_CORE_CONSTS_SVH

// Data and address width
`define RV_XLEN 32

// Register index width for 32 architectural registers
`define RV_REG_AW 5

// PC value after reset
`define RV_RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define RV_NOP 32'h0000_0013

`endif

// File: common/rv_core_pkg.sv
// ############################
// rv_core package
// Enums and control bundles shared by the core blocks
// ############################

`include "rv_core_consts.svh"

package rv_core_pkg;

    // RV32I major opcodes in instr[6:0]
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_sel_e;

    typedef enum logic {
        SRC_REG,
        SRC_IMM
    } alu_src_e;

    typedef enum logic [2:0] {
        WB_ALU,
        WB_LOAD,
        WB_PC4,
        WB_ADD2,
        WB_NONE
    } wb_sel_e;

    // IMM alone is the LUI path through the second adder
    typedef enum logic [1:0] {
        ADD2_PC_IMM,
        ADD2_RS1_IMM,
        ADD2_IMM
    } add2_src_e;

    typedef enum logic {
        PC_SEL_PLUS4,
        PC_SEL_ADD2
    } pc_sel_e;

    typedef struct packed {
        alu_op_e                alu_op;
        alu_src_e               alu_src;
        wb_sel_e                wb_sel;
        add2_src_e              add2_src;
        logic                   reg_write;
        logic                   mem_read;
        logic                   mem_write;
        logic                   is_branch;
        logic                   is_jump;
        logic [2:0]             funct3;
        logic [`RV_REG_AW-1:0]  rs1;
        logic [`RV_REG_AW-1:0]  rs2;
        logic [`RV_REG_AW-1:0]  rd;
    } ctrl_t;

    typedef struct packed {
        logic                   valid;
        logic                   write;
        logic [`RV_XLEN-1:0]    addr;
        logic [`RV_XLEN-1:0]    wdata;
        logic [3:0]             be;
    } dmem_req_t;

endpackage

// File: verilog/pc_unit.sv
// ############################
// rv_core PC unit
// PC register, second adder and next-PC selection
// ############################

`include "rv_core_consts.svh"

module pc_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  rv_core_pkg::ctrl_t      i_ctrl,
    input  logic [`RV_XLEN-1:0]     i_imm,
    input  logic [`RV_XLEN-1:0]     i_rs1_data,
    input  logic                    i_branch_taken,
    input  logic                    i_stall,
    output logic [`RV_XLEN-1:0]     o_pc,
    output logic [`RV_XLEN-1:0]     o_pc_plus4,
    output logic [`RV_XLEN-1:0]     o_add2_result
);

    logic [`RV_XLEN-1:0]    pc;
    logic [`RV_XLEN-1:0]    pc_next;
    rv_core_pkg::pc_sel_e   pc_sel;

    assign o_pc       = pc;
    assign o_pc_plus4 = pc + `RV_XLEN'd4;

    // Second adder that also forms the LUI and AUIPC result
    always_comb begin
        case (i_ctrl.add2_src)
            rv_core_pkg::ADD2_PC_IMM:  o_add2_result = pc + i_imm;
            // JALR clears the target LSB
            rv_core_pkg::ADD2_RS1_IMM: o_add2_result = (i_rs1_data + i_imm) & ~`RV_XLEN'd1;
            default:                   o_add2_result = i_imm;
        endcase
    end

    assign pc_sel = (i_ctrl.is_jump || i_branch_taken) ? rv_core_pkg::PC_SEL_ADD2
                                                       : rv_core_pkg::PC_SEL_PLUS4;

    // Stall wins over any redirect
    always_comb begin
        if (i_stall) begin
            pc_next = pc;
        end else if (pc_sel == rv_core_pkg::PC_SEL_ADD2) begin
            pc_next = o_add2_result;
        end else begin
            pc_next = o_pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= `RV_RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

// File: verilog/decoder.sv
// ############################
// rv_core decoder
// Control bundle and immediate from the fetched word
// ############################

`include "rv_core_consts.svh"

module decoder (
    input  logic [`RV_XLEN-1:0]     i_instr,
    output rv_core_pkg::ctrl_t      o_ctrl,
    output logic [`RV_XLEN-1:0]     o_imm
);

    rv_core_pkg::imm_sel_e  imm_sel;
    logic [2:0]             funct3;

    assign funct3 = i_instr[14:12];

    // Shared funct3 map of OP and OP_IMM where alt selects SUB or SRA
    function automatic rv_core_pkg::alu_op_e alu_op_from_f3(input logic [2:0] f3,
                                                             input logic alt);
        rv_core_pkg::alu_op_e op;
        case (f3)
            3'b000:  op = alt ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
            3'b001:  op = rv_core_pkg::ALU_SLL;
            3'b010:  op = rv_core_pkg::ALU_SLT;
            3'b011:  op = rv_core_pkg::ALU_SLTU;
            3'b100:  op = rv_core_pkg::ALU_XOR;
            3'b101:  op = alt ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
            3'b110:  op = rv_core_pkg::ALU_OR;
            default: op = rv_core_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        // Defaults describe a no-op
        o_ctrl           = '0;
        o_ctrl.alu_op    = rv_core_pkg::ALU_ADD;
        o_ctrl.alu_src   = rv_core_pkg::SRC_REG;
        o_ctrl.wb_sel    = rv_core_pkg::WB_NONE;
        o_ctrl.add2_src  = rv_core_pkg::ADD2_PC_IMM;
        o_ctrl.funct3    = funct3;
        o_ctrl.rs1       = i_instr[19:15];
        o_ctrl.rs2       = i_instr[24:20];
        o_ctrl.rd        = i_instr[11:7];
        imm_sel          = rv_core_pkg::IMM_I;

        case (rv_core_pkg::opcode_e'(i_instr[6:0]))
            rv_core_pkg::OPC_LUI: begin
                imm_sel          = rv_core_pkg::IMM_U;
                o_ctrl.add2_src  = rv_core_pkg::ADD2_IMM;
                o_ctrl.wb_sel    = rv_core_pkg::WB_ADD2;
                o_ctrl.reg_write = 1'b1;
            end
            rv_core_pkg::OPC_AUIPC: begin
                imm_sel          = rv_core_pkg::IMM_U;
                o_ctrl.wb_sel    = rv_core_pkg::WB_ADD2;
                o_ctrl.reg_write = 1'b1;
            end
            rv_core_pkg::OPC_JAL: begin
                imm_sel          = rv_core_pkg::IMM_J;
                o_ctrl.is_jump   = 1'b1;
                o_ctrl.wb_sel    = rv_core_pkg::WB_PC4;
                o_ctrl.reg_write = 1'b1;
            end
            rv_core_pkg::OPC_JALR: begin
                o_ctrl.add2_src  = rv_core_pkg::ADD2_RS1_IMM;
                o_ctrl.is_jump   = 1'b1;
                o_ctrl.wb_sel    = rv_core_pkg::WB_PC4;
                o_ctrl.reg_write = 1'b1;
            end
            rv_core_pkg::OPC_BRANCH: begin
                imm_sel          = rv_core_pkg::IMM_B;
                o_ctrl.is_branch = 1'b1;
                // Equality via SUB and ordering via SLT or SLTU
                case (funct3[2:1])
                    2'b10:   o_ctrl.alu_op = rv_core_pkg::ALU_SLT;
                    2'b11:   o_ctrl.alu_op = rv_core_pkg::ALU_SLTU;
                    default: o_ctrl.alu_op = rv_core_pkg::ALU_SUB;
                endcase
            end
            rv_core_pkg::OPC_LOAD: begin
                o_ctrl.alu_src   = rv_core_pkg::SRC_IMM;
                o_ctrl.mem_read  = 1'b1;
                o_ctrl.wb_sel    = rv_core_pkg::WB_LOAD;
                o_ctrl.reg_write = 1'b1;
            end
            rv_core_pkg::OPC_STORE: begin
                imm_sel          = rv_core_pkg::IMM_S;
                o_ctrl.alu_src   = rv_core_pkg::SRC_IMM;
                o_ctrl.mem_write = 1'b1;
            end
            rv_core_pkg::OPC_OP_IMM: begin
                // instr[30] only matters for the right shifts here
                o_ctrl.alu_op    = alu_op_from_f3(funct3, (funct3 == 3'b101) && i_instr[30]);
                o_ctrl.alu_src   = rv_core_pkg::SRC_IMM;
                o_ctrl.wb_sel    = rv_core_pkg::WB_ALU;
                o_ctrl.reg_write = 1'b1;
            end
            rv_core_pkg::OPC_OP: begin
                o_ctrl.alu_op    = alu_op_from_f3(funct3, i_instr[30]);
                o_ctrl.wb_sel    = rv_core_pkg::WB_ALU;
                o_ctrl.reg_write = 1'b1;
            end
            default: begin
                // Unknown opcode stays a no-op
            end
        endcase
    end

    always_comb begin
        case (imm_sel)
            rv_core_pkg::IMM_S: o_imm = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
            rv_core_pkg::IMM_B: o_imm = {{19{i_instr[31]}}, i_instr[31], i_instr[7],
                                         i_instr[30:25], i_instr[11:8], 1'b0};
            rv_core_pkg::IMM_U: o_imm = {i_instr[31:12], 12'b0};
            rv_core_pkg::IMM_J: o_imm = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12],
                                         i_instr[20], i_instr[30:21], 1'b0};
            default:            o_imm = {{20{i_instr[31]}}, i_instr[31:20]};
        endcase
    end

endmodule

// File: verilog/regfile.sv
// ############################
// rv_core register file
// 32 x 32 registers with x0 hardwired to zero
// ############################

`include "rv_core_consts.svh"

module regfile (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`RV_REG_AW-1:0]   i_rs1,
    input  logic [`RV_REG_AW-1:0]   i_rs2,
    input  logic [`RV_REG_AW-1:0]   i_rd,
    input  logic                    i_we,
    input  logic [`RV_XLEN-1:0]     i_wdata,
    output logic [`RV_XLEN-1:0]     o_rs1_data,
    output logic [`RV_XLEN-1:0]     o_rs2_data
);

    // No storage behind x0
    logic [`RV_XLEN-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_rd != '0)) begin
            regs[i_rd] <= i_wdata;
        end
    end

    assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

// File: verilog/alu.sv
// ############################
// rv_core ALU
// Integer operations and branch compare
// ############################

`include "rv_core_consts.svh"

module alu (
    input  rv_core_pkg::ctrl_t      i_ctrl,
    input  logic [`RV_XLEN-1:0]     i_rs1_data,
    input  logic [`RV_XLEN-1:0]     i_rs2_data,
    input  logic [`RV_XLEN-1:0]     i_imm,
    output logic [`RV_XLEN-1:0]     o_result,
    output logic                    o_branch_taken
);

    logic [`RV_XLEN-1:0]    op_b;
    logic [4:0]             shamt;
    logic                   zero;
    logic                   cond;

    assign op_b  = (i_ctrl.alu_src == rv_core_pkg::SRC_IMM) ? i_imm : i_rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (i_ctrl.alu_op)
            rv_core_pkg::ALU_SUB:  o_result = i_rs1_data - op_b;
            rv_core_pkg::ALU_SLL:  o_result = i_rs1_data << shamt;
            rv_core_pkg::ALU_SLT:  o_result = {31'b0, $signed(i_rs1_data) < $signed(op_b)};
            rv_core_pkg::ALU_SLTU: o_result = {31'b0, i_rs1_data < op_b};
            rv_core_pkg::ALU_XOR:  o_result = i_rs1_data ^ op_b;
            rv_core_pkg::ALU_SRL:  o_result = i_rs1_data >> shamt;
            rv_core_pkg::ALU_SRA:  o_result = $unsigned($signed(i_rs1_data) >>> shamt);
            rv_core_pkg::ALU_OR:   o_result = i_rs1_data | op_b;
            rv_core_pkg::ALU_AND:  o_result = i_rs1_data & op_b;
            default:               o_result = i_rs1_data + op_b;
        endcase
    end

    assign zero = (o_result == '0);

    // Decoder picked SUB for BEQ/BNE and SLT/SLTU for the rest
    always_comb begin
        case (i_ctrl.funct3)
            3'b000:  cond = zero;
            3'b001:  cond = !zero;
            3'b100:  cond = o_result[0];
            3'b101:  cond = !o_result[0];
            3'b110:  cond = o_result[0];
            3'b111:  cond = !o_result[0];
            default: cond = 1'b0;
        endcase
    end

    assign o_branch_taken = i_ctrl.is_branch && cond;

endmodule

// File: verilog/load_store.sv
// ############################
// rv_core load/store unit
// Data request, lane alignment, stall and write-back mux
// ############################

`include "rv_core_consts.svh"

module load_store (
    input  rv_core_pkg::ctrl_t      i_ctrl,
    input  logic [`RV_XLEN-1:0]     i_addr,
    input  logic [`RV_XLEN-1:0]     i_rs2_data,
    input  logic [`RV_XLEN-1:0]     i_alu_result,
    input  logic [`RV_XLEN-1:0]     i_pc_plus4,
    input  logic [`RV_XLEN-1:0]     i_add2_result,
    output rv_core_pkg::dmem_req_t  o_dmem_req,
    input  logic                    i_dmem_ready,
    input  logic [`RV_XLEN-1:0]     i_dmem_rdata,
    output logic                    o_stall,
    output logic                    o_rd_we,
    output logic [`RV_XLEN-1:0]     o_rd_wdata
);

    logic [4:0]             lane_shift;
    logic [3:0]             be;
    logic [`RV_XLEN-1:0]    rdata_shifted;
    logic [`RV_XLEN-1:0]    load_data;

    // Bit offset of the addressed byte lane
    assign lane_shift = {i_addr[1:0], 3'b000};

    always_comb begin
        case (i_ctrl.funct3[1:0])
            2'b00:   be = 4'b0001 << i_addr[1:0];
            2'b01:   be = 4'b0011 << {i_addr[1], 1'b0};
            default: be = 4'b1111;
        endcase
    end

    assign o_dmem_req.valid = i_ctrl.mem_read || i_ctrl.mem_write;
    assign o_dmem_req.write = i_ctrl.mem_write;
    assign o_dmem_req.addr  = i_addr;
    assign o_dmem_req.wdata = i_rs2_data << lane_shift;
    assign o_dmem_req.be    = be;

    // Held until ready, then the instruction retires
    assign o_stall = o_dmem_req.valid && !i_dmem_ready;

    assign rdata_shifted = i_dmem_rdata >> lane_shift;

    always_comb begin
        case (i_ctrl.funct3)
            3'b000:  load_data = {{24{rdata_shifted[7]}}, rdata_shifted[7:0]};
            3'b001:  load_data = {{16{rdata_shifted[15]}}, rdata_shifted[15:0]};
            3'b100:  load_data = {24'b0, rdata_shifted[7:0]};
            3'b101:  load_data = {16'b0, rdata_shifted[15:0]};
            default: load_data = i_dmem_rdata;
        endcase
    end

    always_comb begin
        case (i_ctrl.wb_sel)
            rv_core_pkg::WB_ALU:  o_rd_wdata = i_alu_result;
            rv_core_pkg::WB_LOAD: o_rd_wdata = load_data;
            rv_core_pkg::WB_PC4:  o_rd_wdata = i_pc_plus4;
            rv_core_pkg::WB_ADD2: o_rd_wdata = i_add2_result;
            default:              o_rd_wdata = '0;
        endcase
    end

    assign o_rd_we = i_ctrl.reg_write && !o_stall;

endmodule

// File: verilog/rv_core.sv
// ############################
// rv_core top
// Single-cycle RV32I core that retires one instruction per clock
// Stalls on the data port until ready is seen
// ############################

`include "rv_core_consts.svh"

module rv_core (
    input  logic                    clk,
    input  logic                    rst_n,
    output logic [`RV_XLEN-1:0]     o_imem_addr,
    input  logic [`RV_XLEN-1:0]     i_imem_data,
    output rv_core_pkg::dmem_req_t  o_dmem_req,
    input  logic                    i_dmem_ready,
    input  logic [`RV_XLEN-1:0]     i_dmem_rdata
);

    rv_core_pkg::ctrl_t     ctrl;
    logic [`RV_XLEN-1:0]    imm;
    logic [`RV_XLEN-1:0]    rs1_data;
    logic [`RV_XLEN-1:0]    rs2_data;
    logic [`RV_XLEN-1:0]    alu_result;
    logic                   branch_taken;
    logic [`RV_XLEN-1:0]    pc_plus4;
    logic [`RV_XLEN-1:0]    add2_result;
    logic                   stall;
    logic                   rd_we;
    logic [`RV_XLEN-1:0]    rd_wdata;

    pc_unit u_pc_unit (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_ctrl         (ctrl),
        .i_imm          (imm),
        .i_rs1_data     (rs1_data),
        .i_branch_taken (branch_taken),
        .i_stall        (stall),
        .o_pc           (o_imem_addr),
        .o_pc_plus4     (pc_plus4),
        .o_add2_result  (add2_result)
    );

    decoder u_decoder (
        .i_instr (i_imem_data),
        .o_ctrl  (ctrl),
        .o_imm   (imm)
    );

    regfile u_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_rs1      (ctrl.rs1),
        .i_rs2      (ctrl.rs2),
        .i_rd       (ctrl.rd),
        .i_we       (rd_we),
        .i_wdata    (rd_wdata),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    alu u_alu (
        .i_ctrl         (ctrl),
        .i_rs1_data     (rs1_data),
        .i_rs2_data     (rs2_data),
        .i_imm          (imm),
        .o_result       (alu_result),
        .o_branch_taken (branch_taken)
    );

    // Address and ALU write-back are the same ALU result
    load_store u_load_store (
        .i_ctrl        (ctrl),
        .i_addr        (alu_result),
        .i_rs2_data    (rs2_data),
        .i_alu_result  (alu_result),
        .i_pc_plus4    (pc_plus4),
        .i_add2_result (add2_result),
        .o_dmem_req    (o_dmem_req),
        .i_dmem_ready  (i_dmem_ready),
        .i_dmem_rdata  (i_dmem_rdata),
        .o_stall       (stall),
        .o_rd_we       (rd_we),
        .o_rd_wdata    (rd_wdata)
    );

endmodule

// File: verification/tb_rv_core.sv
// ############################
// rv_core testbench
// Runs a program from the stim file and checks every store
// ############################

`include "rv_core_consts.svh"

module tb_rv_core;

    localparam int STORE_TIMEOUT = 2000;
    localparam int END_TIMEOUT   = 50;

    logic                    clk = 1'b0;
    logic                    rst_n = 1'b0;
    logic [`RV_XLEN-1:0]     imem_addr;
    logic [`RV_XLEN-1:0]     imem_data;
    rv_core_pkg::dmem_req_t  dmem_req;
    logic                    dmem_ready = 1'b0;
    logic [`RV_XLEN-1:0]     dmem_rdata;

    logic [31:0]  rom [0:255];
    logic [31:0]  mem [0:255];
    int unsigned  prog_len;

    // Expected store records
    logic [31:0]  exp_addr [$];
    logic [31:0]  exp_data [$];
    logic [3:0]   exp_be [$];
    string        exp_test [$];
    int           n_exp;
    int           n_seen = 0;
    int           store_errors = 0;
    int           test_errors = 0;

    logic         pending = 1'b0;
    int           ready_delay = 0;
    int           stall_cycles = 0;

    rv_core u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .o_imem_addr  (imem_addr),
        .i_imem_data  (imem_data),
        .o_dmem_req   (dmem_req),
        .i_dmem_ready (dmem_ready),
        .i_dmem_rdata (dmem_rdata)
    );

    always #4 clk = ~clk;

    // Instruction ROM answers in the same cycle and returns NOP past the program
    assign imem_data  = (imem_addr < (prog_len << 2)) ? rom[imem_addr[9:2]] : `RV_NOP;

    // Read data only carries the word in the handshake cycle of a load
    assign dmem_rdata = (dmem_req.valid && !dmem_req.write && dmem_ready)
                        ? mem[dmem_req.addr[9:2]] : 32'hDEAD_BEEF;

    task automatic read_stim();
        int          fd;
        int          r;
        string       line;
        string       name;
        logic [31:0] word;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] b;
        prog_len = 0;
        fd = $fopen("verification/rv_core_stim.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file");
            store_errors++;
        end else begin
            while (!$feof(fd)) begin
                r = $fgets(line, fd);
                if (r == 0 || line.len() == 0) begin
                    continue;
                end
                if (line[0] == "I") begin
                    r = $sscanf(line, "I %h", word);
                    rom[prog_len[7:0]] = word;
                    prog_len++;
                end else if (line[0] == "S") begin
                    r = $sscanf(line, "S %h %h %h %s", a, d, b, name);
                    exp_addr.push_back(a);
                    exp_data.push_back(d);
                    exp_be.push_back(b[3:0]);
                    exp_test.push_back(name);
                end
            end
            $fclose(fd);
        end
        n_exp = exp_addr.size();
    endtask

    task automatic check_store(input rv_core_pkg::dmem_req_t req);
        string name;
        if (n_seen >= n_exp) begin
            $display("Unexpected extra store to %h with data %h", req.addr, req.wdata);
            store_errors++;
        end else begin
            name = exp_test[n_seen];
            if (req.addr != exp_addr[n_seen]) begin
                $display("FAIL %s addr: expected %h, actual %h", name,
                         exp_addr[n_seen], req.addr);
                test_errors++;
            end
            if (req.wdata != exp_data[n_seen]) begin
                $display("FAIL %s data: expected %h, actual %h", name,
                         exp_data[n_seen], req.wdata);
                test_errors++;
            end
            if (req.be != exp_be[n_seen]) begin
                $display("FAIL %s be: expected %b, actual %b", name,
                         exp_be[n_seen], req.be);
                test_errors++;
            end
            n_seen++;
            if (n_seen == n_exp || exp_test[n_seen] != name) begin
                $display("test %s finished with %0d errors", name, test_errors);
                store_errors += test_errors;
                test_errors = 0;
            end
        end
    endtask

    // Handshake sampled mid-cycle where the DUT outputs are stable
    always @(negedge clk) begin
        if (rst_n && dmem_req.valid && dmem_ready) begin
            if (dmem_req.write) begin
                for (int b = 0; b < 4; b++) begin
                    if (dmem_req.be[b]) begin
                        mem[dmem_req.addr[9:2]][8*b +: 8] = dmem_req.wdata[8*b +: 8];
                    end
                end
                check_store(dmem_req);
            end
        end
    end

    // Random 0 to 3 wait cycles for each new request
    always @(posedge clk) begin
        #1;
        if (!rst_n || !dmem_req.valid) begin
            dmem_ready = 1'b0;
            pending = 1'b0;
        end else if (!pending || dmem_ready) begin
            ready_delay = $urandom % 4;
            pending = 1'b1;
            dmem_ready = (ready_delay == 0);
        end else begin
            stall_cycles++;
            if (ready_delay > 0) begin
                ready_delay--;
            end
            dmem_ready = (ready_delay == 0);
        end
    end

    initial begin
        int cycles;
        int run_errors;
        run_errors = 0;
        void'($urandom(32'h00db630c));
        for (int i = 0; i < 256; i++) begin
            mem[i] = {8'hA5, i[7:0], 8'h5A, ~i[7:0]};
            rom[i] = `RV_NOP;
        end
        read_stim();
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;

        cycles = 0;
        while (n_seen < n_exp && cycles < STORE_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (n_seen < n_exp) begin
            $display("Timed out waiting for stores, %0d of %0d seen", n_seen, n_exp);
            run_errors++;
        end

        cycles = 0;
        while (imem_addr < (prog_len << 2) && cycles < END_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (imem_addr < (prog_len << 2)) begin
            $display("PC did not reach the end of the program");
            run_errors++;
        end
        repeat (4) @(posedge clk);

        if (stall_cycles == 0) begin
            $display("No stall cycle was exercised");
            run_errors++;
        end
        $display("test stalls finished with %0d errors, %0d stall cycles",
                 run_errors, stall_cycles);
        $display("stores expected %0d, seen %0d, errors %0d", n_exp, n_seen,
                 store_errors + run_errors);
        if (store_errors + run_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: verification/rv_core_stim.txt
# I <instruction word> : program, from address 0
# S <addr> <wdata> <be> <test> : expected stores in program order
I 10000093 addi x1,x0,0x100
I FFB00113 addi x2,x0,-5
I 00700193 addi x3,x0,7
I 00310233 add x4,x2,x3
I 0040A023 sw x4,0(x1)
I 403102B3 sub x5,x2,x3
I 0050A223 sw x5,4(x1)
I 40115313 srai x6,x2,1
I 0060A423 sw x6,8(x1)
I 01C15393 srli x7,x2,28
I 0070A623 sw x7,12(x1)
I 00419413 slli x8,x3,4
I 00244433 xor x8,x8,x2
I 0080A823 sw x8,16(x1)
I 003124B3 slt x9,x2,x3
I 00313533 sltu x10,x2,x3
I 40A484B3 sub x9,x9,x10
I 0090AA23 sw x9,20(x1)
I 003265B3 or x11,x4,x3
I 0025F5B3 and x11,x11,x2
I 00B0AC23 sw x11,24(x1)
I ABCDE637 lui x12,0xabcde
I 00C0AE23 sw x12,28(x1)
I 00500013 addi x0,x0,5
I 0200A023 sw x0,32(x1)
I 123456B7 lui x13,0x12345
I 67868693 addi x13,x13,0x678
I 02D08823 sb x13,0x30(x1)
I 02D088A3 sb x13,0x31(x1)
I 02D09923 sh x13,0x32(x1)
I 02D08BA3 sb x13,0x37(x1)
I 02D09C23 sh x13,0x38(x1)
I 00408703 lb x14,4(x1)
I 04E0A023 sw x14,0x40(x1)
I 0050C703 lbu x14,5(x1)
I 04E0A223 sw x14,0x44(x1)
I 00609703 lh x14,6(x1)
I 04E0A423 sw x14,0x48(x1)
I 0040D703 lhu x14,4(x1)
I 04E0A623 sw x14,0x4c(x1)
I 0300A703 lw x14,0x30(x1)
I 04E0A823 sw x14,0x50(x1)
# Each branch group: taken skips sw x0, not taken falls into sw x3
I 00318463 beq x3,x3,+8
I 0600A023 sw x0,0x60(x1)
I 00310463 beq x2,x3,+8
I 0630A023 sw x3,0x60(x1)
I 00311463 bne x2,x3,+8
I 0600A023 sw x0,0x60(x1)
I 00319463 bne x3,x3,+8
I 0630A023 sw x3,0x60(x1)
I 00314463 blt x2,x3,+8
I 0600A023 sw x0,0x60(x1)
I 0021C463 blt x3,x2,+8
I 0630A023 sw x3,0x60(x1)
I 0021D463 bge x3,x2,+8
I 0600A023 sw x0,0x60(x1)
I 00315463 bge x2,x3,+8
I 0630A023 sw x3,0x60(x1)
I 0021E463 bltu x3,x2,+8
I 0600A023 sw x0,0x60(x1)
I 00316463 bltu x2,x3,+8
I 0630A023 sw x3,0x60(x1)
I 00317463 bgeu x2,x3,+8
I 0600A023 sw x0,0x60(x1)
I 0021F463 bgeu x3,x2,+8
I 0630A023 sw x3,0x60(x1)
I 0080076F jal x14,+8
I 0600A023 sw x0,0x60(x1)
I 06E0A223 sw x14,0x64(x1)
I 12400793 addi x15,x0,0x124
I 00078867 jalr x16,0(x15)
I 0600A023 sw x0,0x60(x1)
I 0600A023 sw x0,0x60(x1)
I 0700A423 sw x16,0x68(x1)
I 00001897 auipc x17,1
I 0710A623 sw x17,0x6c(x1)
S 00000100 00000002 f arith
S 00000104 FFFFFFF4 f arith
S 00000108 FFFFFFFD f arith
S 0000010C 0000000F f arith
S 00000110 FFFFFF8B f arith
S 00000114 00000001 f arith
S 00000118 00000003 f arith
S 0000011C ABCDE000 f arith
S 00000120 00000000 f arith
S 00000130 12345678 1 stores
S 00000131 34567800 2 stores
S 00000132 56780000 c stores
S 00000137 78000000 8 stores
S 00000138 12345678 3 stores
S 00000140 FFFFFFF4 f loads
S 00000144 000000FF f loads
S 00000148 FFFFFFFF f loads
S 0000014C 0000FFF4 f loads
S 00000150 56787878 f loads
S 00000160 00000007 f branches
S 00000160 00000007 f branches
S 00000160 00000007 f branches
S 00000160 00000007 f branches
S 00000160 00000007 f branches
S 00000160 00000007 f branches
S 00000164 0000010C f jumps
S 00000168 0000011C f jumps
S 0000016C 00001128 f jumps

// File: list.f
+incdir+common
common/rv_core_pkg.sv
verilog/pc_unit.sv
verilog/decoder.sv
verilog/regfile.sv
verilog/alu.sv
verilog/load_store.sv
verilog/rv_core.sv
verification/tb_rv_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= NO ERRORS

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
